/* all.f */
source/vec_cfg_pkg.sv
source/vec_op_pkg.sv
source/vec_issue_decode.sv
source/vreg_addr_gen.sv
source/vreg_file.sv
source/vec_lane_alu.sv
source/vec_writeback.sv
source/vector_exec_unit.sv
testbench/vec_exec_asserts.sv
testbench/tb_vector_exec_unit.sv

/* Bender.yml */
package:
  name: vector_exec_unit

sources:
  - source/vec_cfg_pkg.sv
  - source/vec_op_pkg.sv
  - source/vec_issue_decode.sv
  - source/vreg_addr_gen.sv
  - source/vreg_file.sv
  - source/vec_lane_alu.sv
  - source/vec_writeback.sv
  - source/vector_exec_unit.sv
  - target: simulation
    files:
      - testbench/vec_exec_asserts.sv
      - testbench/tb_vector_exec_unit.sv

/* testbench/tb_vector_exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// random instruction stream checked against a behavioral model of the vector slice
module tb_vector_exec_unit
    import vec_cfg_pkg::*;
    import vec_op_pkg::*;
();

    localparam int num_instr      = 300;
    localparam int reset_cycles   = 16;
    localparam int timeout_cycles = num_instr * 16 + 64;   // longest group plus slack, per instr

    logic       clk;
    logic       rst_n;
    logic       issue_valid;
    vec_issue_t issue;
    logic       ready;
    logic       wb_valid;
    wb_result_t wb;

    integer seed = 32'heb2b_a335;
    int     cyc = 0;            // rising edges seen so far

    logic [vlen-1:0] model_regs [num_vregs];   // architectural state as the model sees it
    wb_result_t      exp_q [$];                // expected results in arrival order
    int              exp_cyc_q [$];            // cycle in which each result must show up
    string           exp_name_q [$];

    vector_exec_unit u_vector_exec_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .ready       (ready),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) begin
            $display("timeout: the run went past %0d cycles without finishing", timeout_cycles);
            stop_on_error();
        end
    end

    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_result(string name, wb_result_t exp, wb_result_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected vd=%0d data=%h last=%b, actual vd=%0d data=%h last=%b",
                     name, exp.vd, exp.data, exp.last, act.vd, act.data, act.last);
            stop_on_error();
        end
    endtask

    task automatic check_ready(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_cycle(string name, int exp, int act);
        if (act != exp) begin
            $display("MISMATCH %s arrival cycle: expected %0d, actual %0d", name, exp, act);
            stop_on_error();
        end
    endtask

    // integer vlmul settings give 2^vlmul registers, all others touch just one
    function automatic int group_len(vlmul_e v);
        case (v)
            lmul_2:  return 2;
            lmul_4:  return 4;
            lmul_8:  return 8;
            default: return 1;
        endcase
    endfunction

    function automatic logic [elem_w-1:0] lane_op(vec_opcode_e op, logic [elem_w-1:0] a,
                                                  logic [elem_w-1:0] b, logic [elem_w-1:0] imm);
        case (op)
            op_vadd:   return a + b;   // 8-bit result drops the carry
            op_vsub:   return a - b;
            op_vand:   return a & b;
            op_vxor:   return a ^ b;
            op_vsplat: return imm;
            default:   return '0;
        endcase
    endfunction

    // true when a source register would be read after the same register was already
    // rewritten earlier in this group, which the in-order model cannot describe
    function automatic bit overlap_hazard(logic [vreg_addr_w-1:0] vs,
                                          logic [vreg_addr_w-1:0] vd, int n);
        for (int j = 0; j < n; j++) begin
            for (int k = 0; k < n; k++) begin
                if (vreg_addr_w'(vs + j) == vreg_addr_w'(vd + k) && k + 2 <= j) begin
                    return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    function automatic vec_issue_t random_issue();
        vec_issue_t ins;
        int         n;
        ins.opcode = vec_opcode_e'(3'($unsigned($random(seed)) % 5));
        ins.vlmul  = vlmul_e'(3'($random(seed)));
        ins.vs1    = vreg_addr_w'($random(seed));
        ins.vs2    = vreg_addr_w'($random(seed));
        ins.vd     = vreg_addr_w'($random(seed));
        ins.imm    = elem_w'($random(seed));
        n = group_len(ins.vlmul);
        if (overlap_hazard(ins.vs1, ins.vd, n)) begin
            ins.vs1 = ins.vd;   // same base is safe, each register is read before it is rewritten
        end
        if (overlap_hazard(ins.vs2, ins.vd, n)) begin
            ins.vs2 = ins.vd;
        end
        return ins;
    endfunction

    // expected results of one instruction, first result four edges after the drive edge
    task automatic model_issue(vec_issue_t ins, int drive_cyc, int idx);
        int              n;
        logic [vlen-1:0] src_a [8];
        logic [vlen-1:0] src_b [8];
        wb_result_t      r;
        n = group_len(ins.vlmul);
        for (int k = 0; k < n; k++) begin
            src_a[k] = model_regs[vreg_addr_w'(ins.vs1 + k)];
            src_b[k] = model_regs[vreg_addr_w'(ins.vs2 + k)];
        end
        for (int k = 0; k < n; k++) begin
            r.vd = vreg_addr_w'(ins.vd + k);      // wraps from v31 to v0
            for (int l = 0; l < num_lanes; l++) begin
                r.data[l*elem_w +: elem_w] = lane_op(ins.opcode, src_a[k][l*elem_w +: elem_w],
                                                     src_b[k][l*elem_w +: elem_w], ins.imm);
            end
            r.last = (k == n - 1);
            model_regs[r.vd] = r.data;
            exp_q.push_back(r);
            exp_cyc_q.push_back(drive_cyc + 4 + k);
            exp_name_q.push_back($sformatf("instr %0d reg %0d", idx, k));
        end
    endtask

    task automatic send_issue(vec_issue_t ins, int idx);
        int idle;
        while (ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        idle = $unsigned($random(seed)) % 3;
        repeat (idle) begin
            @(posedge clk);
            #1;
        end
        check_ready($sformatf("ready before instr %0d", idx), 1'b1, ready);
        issue_valid = 1'b1;
        issue       = ins;
        model_issue(ins, cyc, idx);
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
        check_ready($sformatf("ready after accepting instr %0d", idx), 1'b0, ready);
        // now and then a strobe while busy, the unit has to ignore it
        if ($unsigned($random(seed)) % 4 == 0) begin
            issue_valid = 1'b1;
            issue       = random_issue();
            @(posedge clk);
            #1;
            issue_valid = 1'b0;
        end
    endtask

    always @(negedge clk) begin : result_monitor
        wb_result_t exp;
        int         exp_cyc;
        string      name;
        if (rst_n && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected result for v%0d with no instruction outstanding", wb.vd);
                stop_on_error();
            end else begin
                exp     = exp_q.pop_front();
                exp_cyc = exp_cyc_q.pop_front();
                name    = exp_name_q.pop_front();
                check_result(name, exp, wb);
                check_cycle(name, exp_cyc, cyc);
            end
        end
    end

    initial begin
        vec_issue_t ins;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_ready("ready after reset", 1'b1, ready);
        check_ready("wb_valid after reset", 1'b0, wb_valid);
        for (int i = 0; i < num_instr; i++) begin
            if (i < num_vregs) begin
                ins.opcode = op_vsplat;   // give every register a known value first
                ins.vlmul  = lmul_1;
                ins.vs1    = '0;
                ins.vs2    = '0;
                ins.vd     = vreg_addr_w'(i);
                ins.imm    = elem_w'($random(seed));
            end else begin
                ins = random_issue();
            end
            send_issue(ins, i);
        end
        while (exp_q.size() != 0 || ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);   // nothing else may come out after the last group
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/vec_exec_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

// issue and writeback protocol, watched where decoder and writeback meet in the top level
module vec_exec_asserts
    import vec_op_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       issue_valid,
    input  logic       ready,
    input  logic       start,
    input  logic       done,
    input  logic       wb_valid,
    input  wb_result_t wb
);

    // start only ever follows an issue that was taken while idle
    assert property (@(posedge clk) disable iff (!rst_n)
        start |-> $past(issue_valid && ready))
        else $error("start pulsed without an accepted issue");

    assert property (@(posedge clk) disable iff (!rst_n)
        (issue_valid && ready) |=> !ready)
        else $error("ready stayed high after an issue was accepted");

    // busy ends only through done
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ready) |-> $past(done))
        else $error("ready came back without a done pulse");

    assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (wb_valid && wb.last))
        else $error("done without the last result of a group");

    assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid && wb.last) |-> done)
        else $error("last result of a group without done");

endmodule

bind vector_exec_unit vec_exec_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .ready       (ready),
    .start       (start),
    .done        (done),
    .wb_valid    (wb_valid),
    .wb          (wb)
);

`default_nettype wire

/* source/vector_exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// vector execution slice: decode, group walk, register read, lane ALU, writeback
module vector_exec_unit
    import vec_cfg_pkg::*;
    import vec_op_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       issue_valid,
    input  vec_issue_t issue,
    output logic       ready,      // an issue is taken only while this is high
    output logic       wb_valid,
    output wb_result_t wb
);

    vec_issue_t             instr;       // instruction held by the decoder
    logic                   start;
    logic                   done;
    logic [vreg_addr_w-1:0] vs1_addr;
    logic [vreg_addr_w-1:0] vs2_addr;
    logic [vreg_addr_w-1:0] vd_addr;
    logic                   vd_last;
    logic                   vd_active;   // the three walks run in lockstep, vd speaks for all
    logic [vlen-1:0]        rdata_a;
    logic [vlen-1:0]        rdata_b;
    alu_req_t               alu_req;
    logic                   alu_valid;
    wb_result_t             alu_res;
    logic                   we;
    logic [vreg_addr_w-1:0] waddr;
    logic [vlen-1:0]        wdata;

    vec_issue_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .done        (done),
        .ready       (ready),
        .start       (start),
        .instr       (instr)
    );

    // same start and vlmul for all three, only the base differs
    vreg_addr_gen u_gen_vs1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .vlmul  (instr.vlmul),
        .base   (instr.vs1),
        .addr   (vs1_addr),
        .first  (),
        .last   (),
        .active ()
    );

    vreg_addr_gen u_gen_vs2 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .vlmul  (instr.vlmul),
        .base   (instr.vs2),
        .addr   (vs2_addr),
        .first  (),
        .last   (),
        .active ()
    );

    vreg_addr_gen u_gen_vd (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .vlmul  (instr.vlmul),
        .base   (instr.vd),
        .addr   (vd_addr),
        .first  (),
        .last   (vd_last),
        .active (vd_active)
    );

    vreg_file u_vreg_file (
        .clk     (clk),
        .raddr_a (vs1_addr),
        .raddr_b (vs2_addr),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata)
    );

    // one register of work for the ALU, built from this cycle's reads
    always_comb begin
        alu_req.opcode = instr.opcode;
        alu_req.vd     = vd_addr;
        alu_req.last   = vd_last;
        alu_req.a      = rdata_a;
        alu_req.b      = rdata_b;
        alu_req.imm    = instr.imm;
    end

    vec_lane_alu u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (vd_active),
        .req       (alu_req),
        .res_valid (alu_valid),
        .res       (alu_res)
    );

    vec_writeback u_writeback (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (alu_valid),
        .res       (alu_res),
        .we        (we),
        .waddr     (waddr),
        .wdata     (wdata),
        .wb_valid  (wb_valid),
        .wb        (wb),
        .done      (done)
    );

endmodule

`default_nettype wire

/* source/vec_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

// writes each finished register into the file and reports it on the result port
module vec_writeback
    import vec_cfg_pkg::*;
    import vec_op_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   res_valid,
    input  wb_result_t             res,
    output logic                   we,
    output logic [vreg_addr_w-1:0] waddr,
    output logic [vlen-1:0]        wdata,
    output logic                   wb_valid,   // one pulse per written register
    output wb_result_t             wb,
    output logic                   done        // goes with the last register of a group
);

    logic       wb_valid_q;
    logic       done_q;
    wb_result_t wb_q;

    // the file takes the ALU result on the same edge that raises wb_valid
    assign we    = res_valid;
    assign waddr = res.vd;
    assign wdata = res.data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            wb_valid_q <= res_valid;
            done_q     <= res_valid && res.last;   // frees the decoder for the next issue
        end
    end

    always_ff @(posedge clk) begin
        wb_q <= res;
    end

    assign wb_valid = wb_valid_q;
    assign wb       = wb_q;
    assign done     = done_q;

endmodule

`default_nettype wire

/* source/vec_lane_alu.sv */
`timescale 1ns/1ps
`default_nettype none

// element-wise operation on the four 8-bit lanes of one register, registered once
module vec_lane_alu
    import vec_cfg_pkg::*;
    import vec_op_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,   // one register of work this cycle
    input  alu_req_t   req,
    output logic       res_valid,
    output wb_result_t res
);

    logic [vlen-1:0] lane_res;   // all lanes, before the register
    logic            valid_q;
    wb_result_t      res_q;

    always_comb begin
        logic [elem_w-1:0] a_lane;
        logic [elem_w-1:0] b_lane;
        lane_res = '0;
        for (int i = 0; i < num_lanes; i++) begin
            a_lane = req.a[i*elem_w +: elem_w];
            b_lane = req.b[i*elem_w +: elem_w];
            // lanes never carry into each other, each one wraps at 8 bits
            case (req.opcode)
                op_vadd:   lane_res[i*elem_w +: elem_w] = a_lane + b_lane;
                op_vsub:   lane_res[i*elem_w +: elem_w] = a_lane - b_lane;   // vs1 minus vs2
                op_vand:   lane_res[i*elem_w +: elem_w] = a_lane & b_lane;
                op_vxor:   lane_res[i*elem_w +: elem_w] = a_lane ^ b_lane;
                op_vsplat: lane_res[i*elem_w +: elem_w] = req.imm;
                default:   lane_res[i*elem_w +: elem_w] = '0;                 // unused opcodes
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid;
        end
    end

    // result payload, qualified by valid_q
    always_ff @(posedge clk) begin
        res_q.vd   <= req.vd;
        res_q.data <= lane_res;
        res_q.last <= req.last;
    end

    assign res_valid = valid_q;
    assign res       = res_q;

endmodule

`default_nettype wire

/* source/vreg_file.sv */
`timescale 1ns/1ps
`default_nettype none

// the 32 vector registers, two asynchronous read ports and one clocked write port
module vreg_file
    import vec_cfg_pkg::*;
(
    input  logic                   clk,
    input  logic [vreg_addr_w-1:0] raddr_a,   // vs1 group
    input  logic [vreg_addr_w-1:0] raddr_b,   // vs2 group
    output logic [vlen-1:0]        rdata_a,
    output logic [vlen-1:0]        rdata_b,
    input  logic                   we,        // from writeback only
    input  logic [vreg_addr_w-1:0] waddr,
    input  logic [vlen-1:0]        wdata
);

    logic [vlen-1:0] mem [num_vregs];   // contents are undefined until first written

    // reads see the array as it stands, a write becomes visible after its edge
    assign rdata_a = mem[raddr_a];
    assign rdata_b = mem[raddr_b];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* source/vreg_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// walks a register group one register per cycle, starting at base
module vreg_addr_gen
    import vec_cfg_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,   // latch base and begin walking
    input  vlmul_e                 vlmul,
    input  logic [vreg_addr_w-1:0] base,
    output logic [vreg_addr_w-1:0] addr,    // register presented this cycle
    output logic                   first,   // addr is the first register of the group
    output logic                   last,    // addr is the final register of the group
    output logic                   active   // addr is valid
);

    typedef enum logic {
        st_idle,
        st_busy
    } state_e;

    state_e                 state_q;
    logic [vreg_addr_w-1:0] addr_q;
    logic [vreg_addr_w-1:0] final_q;   // register number where the walk stops
    logic                   first_q;
    logic [vreg_addr_w-1:0] span;      // group length minus one

    // integer settings give 2^vlmul registers, everything with the top bit set gives one
    always_comb begin
        case (vlmul)
            lmul_2:  span = vreg_addr_w'(1);
            lmul_4:  span = vreg_addr_w'(3);
            lmul_8:  span = vreg_addr_w'(7);
            default: span = '0;                 // lmul_1, reserved and fractional
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            addr_q  <= '0;
            final_q <= '0;
            first_q <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (start) begin
                        state_q <= st_busy;
                        addr_q  <= base;
                        final_q <= base + span;   // wraps modulo 32 on its own
                        first_q <= 1'b1;
                    end
                end
                st_busy: begin
                    first_q <= 1'b0;
                    if (addr_q == final_q) begin
                        state_q <= st_idle;       // group finished, wait for the next start
                    end else begin
                        addr_q <= addr_q + 1'b1;  // v31 rolls over to v0
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    assign active = (state_q == st_busy);
    assign addr   = addr_q;
    assign first  = first_q;
    assign last   = active && (addr_q == final_q);   // single-register groups are first and last

endmodule

`default_nettype wire

/* source/vec_issue_decode.sv */
`timescale 1ns/1ps
`default_nettype none

// accepts one instruction at a time and holds it until its whole group is written back
module vec_issue_decode
    import vec_op_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       issue_valid,  // one-cycle strobe from outside
    input  vec_issue_t issue,
    input  logic       done,         // last register of the group has been written
    output logic       ready,
    output logic       start,        // kicks the address generators once per instruction
    output vec_issue_t instr         // held instruction, stable while busy
);

    logic       busy_q;   // an instruction is somewhere in the pipe
    logic       start_q;
    vec_issue_t instr_q;
    logic       accept;   // issue strobe seen while idle

    // a strobe that shows up while busy is simply dropped
    assign accept = issue_valid && !busy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= accept;          // high for exactly the cycle after acceptance
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;         // ready is back in the cycle after done
            end
        end
    end

    // the instruction itself needs no reset, nothing looks at it before start
    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= issue;
        end
    end

    assign ready = !busy_q;
    assign start = start_q;
    assign instr = instr_q;

endmodule

`default_nettype wire

/* source/vec_op_pkg.sv */
`default_nettype none

// operations and the records handed from one stage to the next
package vec_op_pkg;

    import vec_cfg_pkg::*;

    // lane operations understood by the ALU
    typedef enum logic [2:0] {
        op_vadd   = 3'd0,   // a + b per lane, wrapping
        op_vsub   = 3'd1,   // a - b per lane, wrapping
        op_vand   = 3'd2,
        op_vxor   = 3'd3,
        op_vsplat = 3'd4    // imm copied into every lane, sources ignored
    } vec_opcode_e;

    // one instruction as it arrives on the issue port
    typedef struct packed {
        vec_opcode_e            opcode;
        vlmul_e                 vlmul;
        logic [vreg_addr_w-1:0] vs1;   // base of the first source group
        logic [vreg_addr_w-1:0] vs2;   // base of the second source group
        logic [vreg_addr_w-1:0] vd;    // base of the destination group
        logic [elem_w-1:0]      imm;   // only used by splat
    } vec_issue_t;

    // work for a single register of the group, as seen by the ALU
    typedef struct packed {
        vec_opcode_e            opcode;
        logic [vreg_addr_w-1:0] vd;
        logic                   last;  // final register of the group
        logic [vlen-1:0]        a;     // read from the vs1 group
        logic [vlen-1:0]        b;     // read from the vs2 group
        logic [elem_w-1:0]      imm;
    } alu_req_t;

    // one finished register on its way to the file and the result port
    typedef struct packed {
        logic [vreg_addr_w-1:0] vd;
        logic [vlen-1:0]        data;
        logic                   last;
    } wb_result_t;

endpackage

`default_nettype wire

/* source/vec_cfg_pkg.sv */
`default_nettype none

// geometry of the vector register file and the register grouping setting
package vec_cfg_pkg;

    localparam int vreg_addr_w = 5;    // enough bits to name every register
    localparam int num_vregs   = 32;   // architectural vector registers v0 to v31
    localparam int elem_w      = 8;    // only 8-bit elements are supported
    localparam int num_lanes   = 4;    // elements packed into one register

    // a register is exactly its lanes laid side by side, lane 0 at the bottom
    localparam int vlen = elem_w * num_lanes;

    // vlmul encodings as in the vector spec
    // the top bit marks fractional settings (and the reserved one), which touch one register
    typedef enum logic [2:0] {
        lmul_1    = 3'd0,   // one register
        lmul_2    = 3'd1,   // group of two
        lmul_4    = 3'd2,   // group of four
        lmul_8    = 3'd3,   // group of eight
        lmul_rsvd = 3'd4,   // reserved, treated like a single register
        lmul_f8   = 3'd5,
        lmul_f4   = 3'd6,
        lmul_f2   = 3'd7
    } vlmul_e;

endpackage

`default_nettype wire
